// ==== test/csb_patterns.txt ====
// Columns: word0 word1 word2 weight_addr data_addr writeback_addr port_mask engine name_idx
// Engine is one-hot {avepool, maxpool, conv}, name_idx selects the test name

// conv1x1, 32 output channels, two groups
03401a01 00200003 00120b0d 10000000 20000000 30000000 c 1 0

// conv3x3, 20 output channels round up to two groups
00d00d02 00140010 00240b0d 10004000 20004000 30004000 3 1 1

// padded conv3x3, 48 output channels, three groups
0034070b 00300020 00080507 10008000 20008000 30008000 f 1 2

// maxpool, zero output channels still needs one group
00900c04 00000040 0001060c 1000c000 2000c000 3000c000 3 2 3

// avepool, 16 output channels, one group
00a90d05 00100010 0002010d 10010000 20010000 30010000 3 4 4

// op type 6, no engine and no port, completes anyway
fffffff6 00400008 00030303 1fff0000 2fff0000 3fff0000 0 0 5

// ==== tb.f ====
src/csb_pkg.sv
src/csb_fifo.sv
src/cmd_decoder.sv
src/op_dispatcher.sv
src/done_tracker.sv
src/csb_top.sv
test/tb_csb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the CSB testbench, from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal -f tb.f --top-module tb_csb -o tb_csb_sim \
    && ./obj_dir/tb_csb_sim | tee sim.log \
    || { echo "Build or run error"; exit 1; }

grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "sim passed" sim.log || { echo "FAIL: no result in sim.log"; exit 1; }
echo "PASS"

// ==== test/tb_csb.sv ====
`default_nettype none

module tb_csb;

    timeunit 1ns;
    timeprecision 1ps;

    import csb_pkg::*;

    localparam int NUM_CMDS = 6;
    localparam int PAT_COLS = 9;  // Six words, port mask, engine, name index

    logic        clk;
    logic        rst_n;
    logic        i_op_en;
    logic        i_cmd_valid;
    logic        o_cmd_ready;
    logic [31:0] i_cmd_word;
    logic [6:0]  i_cmd_count;
    logic        i_irq_clr;
    logic [2:0]  o_op_type;
    logic [15:0] o_op_num;
    logic [31:0] o_weight_start_addr;
    logic [31:0] o_data_start_addr;
    logic [31:0] o_writeback_addr;
    logic        o_padding;
    logic [7:0]  o_stride_1;
    logic [15:0] o_stride_2;
    logic [15:0] o_i_channel_size;
    logic [7:0]  o_i_kernel_size;
    logic [7:0]  o_o_kernel_size;
    logic [3:0]  o_port_rd_en;
    logic        o_conv_ready;
    logic        i_conv_valid;
    logic        o_maxpool_ready;
    logic        i_maxpool_valid;
    logic        o_avepool_ready;
    logic        i_avepool_valid;
    logic        o_op_run;
    logic [6:0]  o_ops_done;
    logic        o_irq;

    logic [31:0] pat [NUM_CMDS * PAT_COLS];
    string       test_names [NUM_CMDS] = '{"conv1x1", "conv3x3", "conv3x3_pad",
                                           "maxpool", "avepool", "unsupported_op"};
    logic        patterns_loaded = 1'b0;
    int          errors = 0;
    int          words_sent = 0;  // Words accepted by the DUT
    int          run_count = 0;   // Rises of o_op_run so far
    int          win_idx = 0;     // Command that owns the dispatch window
    int          beats = 0;       // Groups counted in this window
    int          windows = 0;     // Dispatch windows opened so far
    logic        prev_run = 1'b0;
    logic        prev_win = 1'b0;
    logic [31:0] cmd_rng = 32'd66;  // LCG seed 66
    logic [31:0] eng_rng = 32'd66;

    csb_top DUT (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;  // 100 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Word n of the whole command stream
    function automatic logic [31:0] word_at(input int n);
        return pat[(n / CMD_WORDS) * PAT_COLS + (n % CMD_WORDS)];
    endfunction

    // Output channels over N_PAR rounded up with a floor of one
    function automatic int expected_groups(input int cmd);
        int och;
        och = int'(pat[cmd * PAT_COLS + 1][31:16]);
        return (och == 0) ? 1 : (och + N_PAR - 1) / N_PAR;
    endfunction

    // Commands that own an engine or a read port
    function automatic int count_engine_cmds();
        int k;
        int n;
        n = 0;
        for (k = 0; k < NUM_CMDS; k++) begin
            if (pat[k * PAT_COLS + 6] != 0 || pat[k * PAT_COLS + 7] != 0) n++;
        end
        return n;
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("ERR %s %s: expected %h, got %h", test, field, exp, act);
        end
    endtask

    // Layer outputs against the fields of command k
    task automatic check_decode(input int k);
        int          base;
        string       name;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        assert (k < NUM_CMDS) else begin
            errors++;
            $display("An op started after all %0d commands had run", NUM_CMDS);
        end
        if (k >= NUM_CMDS) return;
        base = k * PAT_COLS;
        name = test_names[pat[base + 8]];
        w0   = pat[base];
        w1   = pat[base + 1];
        w2   = pat[base + 2];
        check_value(name, "op_type", w0[2:0], o_op_type);
        check_value(name, "padding", w0[3], o_padding);
        check_value(name, "stride_1", w0[15:8], o_stride_1);
        check_value(name, "stride_2", w0[31:16], o_stride_2);
        check_value(name, "i_channel_size", w1[15:0], o_i_channel_size);
        check_value(name, "i_kernel_size", w2[7:0], o_i_kernel_size);
        check_value(name, "o_kernel_size", w2[15:8], o_o_kernel_size);
        check_value(name, "op_num", w2[31:16], o_op_num);
        check_value(name, "weight_start_addr", pat[base + 3], o_weight_start_addr);
        check_value(name, "data_start_addr", pat[base + 4], o_data_start_addr);
        check_value(name, "writeback_addr", pat[base + 5], o_writeback_addr);
        check_value(name, "ops_done at start", k, o_ops_done);  // Earlier ops all counted
    endtask

    // Command stream with random idle gaps and valid held until accepted
    task automatic push_commands();
        int   total;
        logic xfer;
        total = NUM_CMDS * CMD_WORDS;
        while (words_sent < total) begin
            @(negedge clk);
            xfer = i_cmd_valid && o_cmd_ready;  // Transfer on the coming edge
            @(posedge clk);
            #5;
            if (xfer) words_sent++;
            if (xfer || !i_cmd_valid) begin
                cmd_rng     = lcg_next(cmd_rng);
                i_cmd_valid = (words_sent < total) && (cmd_rng[31:30] != 2'b00);
                if (words_sent < total) i_cmd_word = word_at(words_sent);
            end
        end
    endtask

    // Engine models raise valid only while the engine owns the op
    always @(posedge clk) begin
        #5;
        eng_rng         = lcg_next(eng_rng);
        i_conv_valid    = o_conv_ready && eng_rng[31];
        i_maxpool_valid = o_maxpool_ready && eng_rng[30];
        i_avepool_valid = o_avepool_ready && eng_rng[29];
    end

    // Monitor on the falling edge where every output is settled
    always @(negedge clk) begin
        logic [2:0] rdy;
        logic [2:0] vld;
        logic       win;
        rdy = {o_avepool_ready, o_maxpool_ready, o_conv_ready};
        vld = {i_avepool_valid, i_maxpool_valid, i_conv_valid};
        win = (rdy != 3'b000) || (o_port_rd_en != 4'b0000);
        if (rst_n) begin
            if (o_op_run && !prev_run) begin
                check_decode(run_count);
                run_count++;
            end
            if (win && !prev_win) begin
                win_idx = run_count;  // Its o_op_run rises one cycle later
                beats   = 0;
                windows++;
            end
            if (win && win_idx < NUM_CMDS) begin
                check_value(test_names[pat[win_idx * PAT_COLS + 8]], "port_rd_en",
                            pat[win_idx * PAT_COLS + 6], o_port_rd_en);
                check_value(test_names[pat[win_idx * PAT_COLS + 8]], "engine ready",
                            pat[win_idx * PAT_COLS + 7], rdy);
                assert (beats < expected_groups(win_idx)) else begin
                    errors++;
                    $display("Engine ready still high after all %0d groups of command %0d",
                             beats, win_idx);
                end
                if ((rdy & vld) != 3'b000) beats++;  // Counted on the next edge
            end else if (win) begin
                errors++;
                $display("Engine ready or port enable raised with no command left");
            end
            if (!win && prev_win && win_idx < NUM_CMDS) begin
                check_value(test_names[pat[win_idx * PAT_COLS + 8]], "groups",
                            expected_groups(win_idx), beats);
            end
            if (o_irq) check_value("irq", "ops_done while irq", NUM_CMDS, o_ops_done);
        end
        prev_run = o_op_run;
        prev_win = win;
    end

    // Watchdog sized from the command set
    initial begin
        int k;
        int max_groups;
        int limit;
        wait (patterns_loaded);
        max_groups = 1;
        for (k = 0; k < NUM_CMDS; k++) begin
            if (expected_groups(k) > max_groups) max_groups = expected_groups(k);
        end
        limit = NUM_CMDS * (CMD_WORDS + 4 * max_groups + 20);
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped making progress", limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        int capacity;
        rst_n           = 1'b0;
        i_op_en         = 1'b0;
        i_cmd_valid     = 1'b0;
        i_cmd_word      = '0;
        i_cmd_count     = 7'(NUM_CMDS);
        i_irq_clr       = 1'b0;
        i_conv_valid    = 1'b0;
        i_maxpool_valid = 1'b0;
        i_avepool_valid = 1'b0;
        $readmemh("test/csb_patterns.txt", pat);
        patterns_loaded = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("reset", "outputs low", '0, {o_cmd_ready, o_conv_ready, o_maxpool_ready,
                    o_avepool_ready, o_port_rd_en, o_op_run, o_irq});
        @(posedge clk);  // Third reset cycle
        #5;
        rst_n = 1'b1;

        fork
            push_commands();
        join_none

        // Word FIFO plus three commands held in the decoder and queue
        capacity = CMD_FIFO_DEPTH + (DESC_FIFO_DEPTH + 1) * CMD_WORDS;
        wait (words_sent >= capacity);
        repeat (4) @(negedge clk);
        check_value("backpressure", "cmd_ready when full", 1'b0, o_cmd_ready);
        check_value("backpressure", "words accepted", capacity, words_sent);

        @(posedge clk);
        #5;
        i_op_en = 1'b1;

        wait (o_ops_done == 7'(NUM_CMDS));
        repeat (2) @(negedge clk);
        check_value("irq", "irq after last op", 1'b1, o_irq);
        check_value("ordering", "ops started", NUM_CMDS, run_count);
        check_value("ordering", "words sent", NUM_CMDS * CMD_WORDS, words_sent);
        check_value("ordering", "dispatch windows", count_engine_cmds(), windows);
        repeat (5) @(negedge clk);
        check_value("irq", "irq sticky", 1'b1, o_irq);
        check_value("irq", "ops_done held", NUM_CMDS, o_ops_done);

        @(posedge clk);
        #5;
        i_irq_clr = 1'b1;
        @(posedge clk);
        #5;
        i_irq_clr = 1'b0;
        @(negedge clk);
        check_value("irq", "irq after clear", 1'b0, o_irq);
        check_value("irq", "ops_done after clear", '0, o_ops_done);

        $display("Checks complete with %0d errors", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/csb_top.sv ====
`default_nettype none

module csb_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_op_en,
    input  logic        i_cmd_valid,
    output logic        o_cmd_ready,
    input  logic [31:0] i_cmd_word,
    input  logic [6:0]  i_cmd_count,
    input  logic        i_irq_clr,
    output logic [2:0]  o_op_type,
    output logic [15:0] o_op_num,
    output logic [31:0] o_weight_start_addr,
    output logic [31:0] o_data_start_addr,
    output logic [31:0] o_writeback_addr,
    output logic        o_padding,
    output logic [7:0]  o_stride_1,
    output logic [15:0] o_stride_2,
    output logic [15:0] o_i_channel_size,
    output logic [7:0]  o_i_kernel_size,
    output logic [7:0]  o_o_kernel_size,
    output logic [3:0]  o_port_rd_en,
    output logic        o_conv_ready,
    input  logic        i_conv_valid,
    output logic        o_maxpool_ready,
    input  logic        i_maxpool_valid,
    output logic        o_avepool_ready,
    input  logic        i_avepool_valid,
    output logic        o_op_run,
    output logic [6:0]  o_ops_done,
    output logic        o_irq
);

    import csb_pkg::*;

    logic        wf_valid;      // Word FIFO to decoder
    logic        wf_ready;
    logic [31:0] wf_data;
    logic        dq_in_valid;   // Decoder to descriptor queue
    logic        dq_in_ready;
    op_desc_t    dq_in_data;
    logic        dq_out_valid;  // Descriptor queue to dispatcher
    logic        dq_out_ready;
    op_desc_t    dq_out_data;
    logic        op_active;
    logic        op_done;

    csb_fifo #(.T_DATA(logic [31:0]), .DEPTH(CMD_FIFO_DEPTH)) u_word_fifo (
        .clk(clk), .rst_n(rst_n),
        .i_wr_valid(i_cmd_valid), .o_wr_ready(o_cmd_ready), .i_wr_data(i_cmd_word),
        .o_rd_valid(wf_valid), .i_rd_ready(wf_ready), .o_rd_data(wf_data)
    );

    cmd_decoder u_decoder (
        .clk(clk), .rst_n(rst_n),
        .i_word_valid(wf_valid), .o_word_ready(wf_ready), .i_word(wf_data),
        .o_desc_valid(dq_in_valid), .i_desc_ready(dq_in_ready), .o_desc(dq_in_data)
    );

    // Lets the next command decode while the current op runs
    csb_fifo #(.T_DATA(op_desc_t), .DEPTH(DESC_FIFO_DEPTH)) u_desc_fifo (
        .clk(clk), .rst_n(rst_n),
        .i_wr_valid(dq_in_valid), .o_wr_ready(dq_in_ready), .i_wr_data(dq_in_data),
        .o_rd_valid(dq_out_valid), .i_rd_ready(dq_out_ready), .o_rd_data(dq_out_data)
    );

    op_dispatcher u_dispatcher (
        .clk(clk), .rst_n(rst_n), .i_op_en(i_op_en),
        .i_desc_valid(dq_out_valid), .o_desc_ready(dq_out_ready), .i_desc(dq_out_data),
        .o_op_type(o_op_type), .o_op_num(o_op_num),
        .o_weight_start_addr(o_weight_start_addr), .o_data_start_addr(o_data_start_addr),
        .o_writeback_addr(o_writeback_addr), .o_padding(o_padding),
        .o_stride_1(o_stride_1), .o_stride_2(o_stride_2),
        .o_i_channel_size(o_i_channel_size), .o_i_kernel_size(o_i_kernel_size),
        .o_o_kernel_size(o_o_kernel_size), .o_port_rd_en(o_port_rd_en),
        .o_conv_ready(o_conv_ready), .i_conv_valid(i_conv_valid),
        .o_maxpool_ready(o_maxpool_ready), .i_maxpool_valid(i_maxpool_valid),
        .o_avepool_ready(o_avepool_ready), .i_avepool_valid(i_avepool_valid),
        .o_op_active(op_active), .o_op_done(op_done)
    );

    done_tracker u_tracker (
        .clk(clk), .rst_n(rst_n),
        .i_op_active(op_active), .i_op_done(op_done),
        .i_cmd_count(i_cmd_count), .i_irq_clr(i_irq_clr),
        .o_op_run(o_op_run), .o_ops_done(o_ops_done), .o_irq(o_irq)
    );

endmodule

`default_nettype wire

// ==== src/done_tracker.sv ====
`default_nettype none

module done_tracker (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_op_active,
    input  logic       i_op_done,
    input  logic [6:0] i_cmd_count,  // Commands programmed by the host
    input  logic       i_irq_clr,
    output logic       o_op_run,
    output logic [6:0] o_ops_done,
    output logic       o_irq
);

    logic [6:0] ops_cnt;    // Completed ops since the last clear
    logic       all_done;

    // Zero command count never fires
    assign all_done = (i_cmd_count != 7'd0) && (ops_cnt == i_cmd_count);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ops_cnt <= '0;
        end else if (i_irq_clr) begin
            ops_cnt <= '0;  // Host restarts the batch
        end else if (i_op_done) begin
            ops_cnt <= ops_cnt + 1'b1;
        end
    end

    // Sticky interrupt, one cycle behind the count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_irq <= 1'b0;
        end else if (i_irq_clr) begin
            o_irq <= 1'b0;
        end else if (all_done) begin
            o_irq <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_op_run <= 1'b0;
        end else begin
            o_op_run <= i_op_active;  // Busy flag for the host
        end
    end

    assign o_ops_done = ops_cnt;

endmodule

`default_nettype wire

// ==== src/op_dispatcher.sv ====
`default_nettype none

module op_dispatcher (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_op_en,
    input  logic              i_desc_valid,
    output logic              o_desc_ready,
    input  csb_pkg::op_desc_t i_desc,
    output logic [2:0]        o_op_type,
    output logic [15:0]       o_op_num,
    output logic [31:0]       o_weight_start_addr,
    output logic [31:0]       o_data_start_addr,
    output logic [31:0]       o_writeback_addr,
    output logic              o_padding,
    output logic [7:0]        o_stride_1,
    output logic [15:0]       o_stride_2,
    output logic [15:0]       o_i_channel_size,
    output logic [7:0]        o_i_kernel_size,
    output logic [7:0]        o_o_kernel_size,
    output logic [3:0]        o_port_rd_en,
    output logic              o_conv_ready,
    input  logic              i_conv_valid,
    output logic              o_maxpool_ready,
    input  logic              i_maxpool_valid,
    output logic              o_avepool_ready,
    input  logic              i_avepool_valid,
    output logic              o_op_active,
    output logic              o_op_done
);

    import csb_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DONE} state_t;

    state_t      state;
    logic [2:0]  eng_rdy;      // One-hot {avepool, maxpool, conv}
    logic [2:0]  eng_sel;
    logic [3:0]  port_sel;     // Bit n enables DMA read port n
    logic [15:0] grp_cnt;      // Result groups received so far
    logic [15:0] n_groups;     // Groups needed for this op
    logic [15:0] groups;
    logic [16:0] ch_round;     // Channel size rounded up to N_PAR
    logic        accept;
    logic        beat;
    logic        last;

    assign o_desc_ready = i_op_en && (state == ST_IDLE);
    assign accept       = i_desc_valid && o_desc_ready;

    // Ceiling of channels over N_PAR, never below one
    assign ch_round = {1'b0, i_desc.o_channel_size} + 17'(N_PAR - 1);
    assign groups   = (ch_round < 17'(N_PAR)) ? 16'd1 : 16'(ch_round / N_PAR);

    always_comb begin
        port_sel = 4'b0000;
        eng_sel  = 3'b000;
        case (i_desc.op_type)
            OP_CONV1X1:      begin port_sel = 4'b1100; eng_sel = 3'b001; end
            OP_CONV3X3:      begin port_sel = 4'b0011; eng_sel = 3'b001; end
            OP_CONV3X3_PAD:  begin port_sel = 4'b1111; eng_sel = 3'b001; end
            OP_MAXPOOL3X3:   begin port_sel = 4'b0011; eng_sel = 3'b010; end
            OP_AVEPOOL13X13: begin port_sel = 4'b0011; eng_sel = 3'b100; end
            default: ;  // Unsupported ops run with nothing enabled
        endcase
    end

    assign beat = (eng_rdy[0] && i_conv_valid)
               || (eng_rdy[1] && i_maxpool_valid)
               || (eng_rdy[2] && i_avepool_valid);
    // No engine owns the op, so it ends straight away
    assign last = (eng_rdy == 3'b000) || (beat && (grp_cnt == n_groups - 1'b1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            o_op_type    <= OP_IDLE;
            o_port_rd_en <= 4'b0000;
            eng_rdy      <= 3'b000;
            grp_cnt      <= '0;
            n_groups     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state        <= ST_RUN;
                        o_op_type    <= i_desc.op_type;
                        o_port_rd_en <= port_sel;
                        eng_rdy      <= eng_sel;
                        grp_cnt      <= '0;
                        n_groups     <= groups;
                    end
                end
                ST_RUN: begin
                    if (beat) begin
                        grp_cnt <= grp_cnt + 1'b1;  // One group of N_PAR channels
                    end
                    if (last) begin
                        state        <= ST_DONE;
                        o_port_rd_en <= 4'b0000;
                        eng_rdy      <= 3'b000;
                    end
                end
                ST_DONE: state <= ST_IDLE;  // Single done cycle before next accept
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Layer configuration, loaded on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            o_op_num            <= i_desc.op_num;
            o_weight_start_addr <= i_desc.weight_start_addr;
            o_data_start_addr   <= i_desc.data_start_addr;
            o_writeback_addr    <= i_desc.writeback_addr;
            o_padding           <= i_desc.padding;
            o_stride_1          <= i_desc.stride_1;
            o_stride_2          <= i_desc.stride_2;
            o_i_channel_size    <= i_desc.i_channel_size;
            o_i_kernel_size     <= i_desc.i_kernel_size;
            o_o_kernel_size     <= i_desc.o_kernel_size;
        end
    end

    assign o_conv_ready    = eng_rdy[0];
    assign o_maxpool_ready = eng_rdy[1];
    assign o_avepool_ready = eng_rdy[2];
    assign o_op_active     = (state == ST_RUN);
    assign o_op_done       = (state == ST_DONE);  // One-cycle pulse

endmodule

`default_nettype wire

// ==== src/cmd_decoder.sv ====
`default_nettype none

module cmd_decoder (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_word_valid,
    output logic              o_word_ready,
    input  logic [31:0]       i_word,
    output logic              o_desc_valid,
    input  logic              i_desc_ready,
    output csb_pkg::op_desc_t o_desc
);

    import csb_pkg::*;

    logic [2:0] word_cnt;    // Index of the next word within a command
    logic       desc_valid;  // Complete descriptor waiting for the queue
    op_desc_t   desc_q;      // Assembly register
    logic       pop;
    logic       last_word;

    // Stall while a finished descriptor is still held
    assign o_word_ready = !desc_valid || i_desc_ready;
    assign pop          = i_word_valid && o_word_ready;
    assign last_word    = (word_cnt == 3'(CMD_WORDS - 1));

    assign o_desc_valid = desc_valid;
    assign o_desc       = desc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt   <= '0;
            desc_valid <= 1'b0;
        end else begin
            if (desc_valid && i_desc_ready) begin
                desc_valid <= 1'b0;  // Queue took it
            end
            if (pop) begin
                if (last_word) begin
                    word_cnt   <= '0;
                    desc_valid <= 1'b1;  // Presented the cycle after word 5
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // Steer each word into its fields
    always_ff @(posedge clk) begin
        if (pop) begin
            case (word_cnt)
                3'd0: begin
                    desc_q.op_type  <= i_word[2:0];
                    desc_q.padding  <= i_word[3];
                    desc_q.stride_1 <= i_word[15:8];
                    desc_q.stride_2 <= i_word[31:16];
                end
                3'd1: begin
                    desc_q.i_channel_size <= i_word[15:0];
                    desc_q.o_channel_size <= i_word[31:16];
                end
                3'd2: begin
                    desc_q.i_kernel_size <= i_word[7:0];
                    desc_q.o_kernel_size <= i_word[15:8];
                    desc_q.op_num        <= i_word[31:16];
                end
                3'd3: desc_q.weight_start_addr <= i_word;
                3'd4: desc_q.data_start_addr   <= i_word;
                3'd5: desc_q.writeback_addr    <= i_word;
                default: ;  // Counter never reaches 6 or 7
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/csb_fifo.sv ====
`default_nettype none

module csb_fifo #(
    parameter type T_DATA = logic [31:0],
    parameter int  DEPTH  = csb_pkg::CMD_FIFO_DEPTH
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_wr_valid,
    output logic  o_wr_ready,
    input  T_DATA i_wr_data,
    output logic  o_rd_valid,
    input  logic  i_rd_ready,
    output T_DATA o_rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);  // Must hold DEPTH itself

    T_DATA            mem [DEPTH];   // Payload storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;         // Occupancy
    logic [CNT_W-1:0] count_next;
    logic             push;
    logic             pop;

    assign push       = i_wr_valid && o_wr_ready;
    assign pop        = o_rd_valid && i_rd_ready;
    assign o_rd_valid = (count != '0);
    assign o_rd_data  = mem[rd_ptr];  // Head word falls through

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_wr_ready <= 1'b0;  // Held low until out of reset
        end else begin
            count      <= count_next;
            o_wr_ready <= (count_next != CNT_W'(DEPTH));  // Registered full flag
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/csb_pkg.sv ====
`default_nettype none

package csb_pkg;

    // Command framing
    localparam int CMD_WORDS       = 6;   // 32-bit words per layer command
    localparam int N_PAR           = 16;  // Output channels per engine result beat

    // Buffer depths
    localparam int CMD_FIFO_DEPTH  = 8;
    localparam int DESC_FIFO_DEPTH = 2;   // Current op plus one decoded ahead

    // Layer op types, as carried in word 0 bits 2:0
    localparam logic [2:0] OP_IDLE         = 3'd0;
    localparam logic [2:0] OP_CONV1X1      = 3'd1;  // 1x1 conv with ReLU
    localparam logic [2:0] OP_CONV3X3      = 3'd2;  // 3x3 conv with ReLU
    localparam logic [2:0] OP_CONV3X3_PAD  = 3'd3;  // Padded 3x3 and 1x1 conv
    localparam logic [2:0] OP_MAXPOOL3X3   = 3'd4;
    localparam logic [2:0] OP_AVEPOOL13X13 = 3'd5;

    // Decoded layer command
    // Unused bits 7:4 of word 0 are dropped
    typedef struct packed {
        logic [2:0]  op_type;
        logic        padding;
        logic [7:0]  stride_1;           // Line stride
        logic [15:0] stride_2;           // Surface stride
        logic [15:0] i_channel_size;
        logic [15:0] o_channel_size;     // Sets the result group count
        logic [7:0]  i_kernel_size;
        logic [7:0]  o_kernel_size;
        logic [15:0] op_num;             // Ops per MAC array
        logic [31:0] weight_start_addr;
        logic [31:0] data_start_addr;
        logic [31:0] writeback_addr;
    } op_desc_t;

endpackage

`default_nettype wire
